/* include/udp_echo_config.svh */
`ifndef UDP_ECHO_CONFIG_SVH
`define UDP_ECHO_CONFIG_SVH

// number of parallel echo lanes
`define ECHO_LANES 4

// per-lane buffering
// header FIFO holds whole reply headers
`define ECHO_HDR_DEPTH 2
// payload FIFO holds single bytes
`define ECHO_PAYLOAD_DEPTH 16

// datagrams to this UDP port are echoed and all others dropped
`define ECHO_PORT 16'd1234

// our own address 192.168.1.128
`define ECHO_LOCAL_IP {8'd192, 8'd168, 8'd1, 8'd128}

// TTL placed in every reply
`define ECHO_REPLY_TTL 8'd64

`endif

/* verilog/udp_echo_pkg.sv */
package udp_echo_pkg;

    // parsed UDP header with one layout for received and reply side
    typedef struct packed {
        // IP addresses
        logic [31:0] src_ip;
        logic [31:0] dst_ip;
        // time to live from the IP header
        logic [7:0]  ttl;
        // UDP ports
        logic [15:0] src_port;
        logic [15:0] dst_port;
        // UDP length field copied into the reply as is
        logic [15:0] length;
    } udp_hdr_t;

    // one byte of payload
    typedef struct packed {
        logic [7:0] data;
        // final byte of the datagram
        logic       last;
        // error flag that travels with the byte untouched
        logic       user;
    } payload_beat_t;

endpackage

/* verilog/stream_fifo.sv */
`timescale 1ns/1ps

module stream_fifo #(
    parameter type T = logic [7:0],
    parameter int DEPTH = 2
) (
    input  logic clk,
    input  logic rst,

    input  T     in_data,
    input  logic in_valid,
    output logic in_ready,

    output T     out_data,
    output logic out_valid,
    input  logic out_ready
);
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    T mem [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_write;
    logic             do_read;

    assign in_ready  = (count != CNT_W'(DEPTH));
    assign out_valid = (count != '0);
    assign out_data  = mem[rd_ptr];

    assign do_write = in_valid && in_ready;
    assign do_read  = out_valid && out_ready;

    // entry storage
    always_ff @(posedge clk) begin
        if (do_write) begin
            mem[wr_ptr] <= in_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_write) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_read) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // simultaneous read and write leaves the count alone
            if (do_write && !do_read) begin
                count <= count + 1'b1;
            end else if (do_read && !do_write) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

/* verilog/echo_dispatch.sv */
`timescale 1ns/1ps
`include "udp_echo_config.svh"

module echo_dispatch
    import udp_echo_pkg::*;
#(
    parameter int LANES = `ECHO_LANES
) (
    input  logic              clk,
    input  logic              rst,

    input  udp_hdr_t          rx_hdr,
    input  logic              rx_hdr_valid,
    output logic              rx_hdr_ready,
    input  payload_beat_t     rx_beat,
    input  logic              rx_beat_valid,
    output logic              rx_beat_ready,

    output udp_hdr_t          lane_hdr,
    output logic [LANES-1:0]  lane_hdr_valid,
    input  logic [LANES-1:0]  lane_hdr_ready,
    output payload_beat_t     lane_beat,
    output logic [LANES-1:0]  lane_beat_valid,
    input  logic [LANES-1:0]  lane_beat_ready
);
    localparam int PTR_W = (LANES > 1) ? $clog2(LANES) : 1;

    typedef enum logic {ST_HDR, ST_PAYLOAD} state_t;

    state_t           state;
    logic             drop;
    logic [PTR_W-1:0] lane_ptr;
    logic             port_match;
    logic             hdr_fire;
    logic             beat_fire;

    assign port_match = (rx_hdr.dst_port == `ECHO_PORT);

    // a frame for another port is taken at once and thrown away
    assign rx_hdr_ready  = (state == ST_HDR) && (!port_match || lane_hdr_ready[lane_ptr]);
    assign rx_beat_ready = (state == ST_PAYLOAD) && (drop || lane_beat_ready[lane_ptr]);

    assign hdr_fire  = rx_hdr_valid && rx_hdr_ready;
    assign beat_fire = rx_beat_valid && rx_beat_ready;

    // data goes to every lane but only the selected one sees valid
    assign lane_hdr  = rx_hdr;
    assign lane_beat = rx_beat;

    always_comb begin
        lane_hdr_valid  = '0;
        lane_beat_valid = '0;
        lane_hdr_valid[lane_ptr]  = (state == ST_HDR) && rx_hdr_valid && port_match;
        lane_beat_valid[lane_ptr] = (state == ST_PAYLOAD) && rx_beat_valid && !drop;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= ST_HDR;
            drop     <= 1'b0;
            lane_ptr <= '0;
        end else begin
            case (state)
                ST_HDR: begin
                    if (hdr_fire) begin
                        state <= ST_PAYLOAD;
                        drop  <= !port_match;
                    end
                end
                ST_PAYLOAD: begin
                    if (beat_fire && rx_beat.last) begin
                        state <= ST_HDR;
                        // dropped frames do not use up a lane
                        if (!drop) begin
                            lane_ptr <= (lane_ptr == PTR_W'(LANES - 1)) ? '0 : lane_ptr + 1'b1;
                        end
                    end
                end
                default: state <= ST_HDR;
            endcase
        end
    end

endmodule

/* verilog/echo_lane.sv */
`timescale 1ns/1ps
`include "udp_echo_config.svh"

module echo_lane
    import udp_echo_pkg::*;
(
    input  logic          clk,
    input  logic          rst,

    input  udp_hdr_t      in_hdr,
    input  logic          in_hdr_valid,
    output logic          in_hdr_ready,
    input  payload_beat_t in_beat,
    input  logic          in_beat_valid,
    output logic          in_beat_ready,

    output udp_hdr_t      out_hdr,
    output logic          out_hdr_valid,
    input  logic          out_hdr_ready,
    output payload_beat_t out_beat,
    output logic          out_beat_valid,
    input  logic          out_beat_ready
);
    udp_hdr_t reply_hdr;

    // turn the request header around before it is stored
    always_comb begin
        reply_hdr.src_ip   = `ECHO_LOCAL_IP;
        reply_hdr.dst_ip   = in_hdr.src_ip;
        reply_hdr.ttl      = `ECHO_REPLY_TTL;
        reply_hdr.src_port = in_hdr.dst_port;
        reply_hdr.dst_port = in_hdr.src_port;
        reply_hdr.length   = in_hdr.length;
    end

    stream_fifo #(.T(udp_hdr_t), .DEPTH(`ECHO_HDR_DEPTH)) hdr_fifo (
        .clk       (clk),
        .rst       (rst),
        .in_data   (reply_hdr),
        .in_valid  (in_hdr_valid),
        .in_ready  (in_hdr_ready),
        .out_data  (out_hdr),
        .out_valid (out_hdr_valid),
        .out_ready (out_hdr_ready)
    );

    // payload bytes pass unchanged with their user flag
    stream_fifo #(.T(payload_beat_t), .DEPTH(`ECHO_PAYLOAD_DEPTH)) beat_fifo (
        .clk       (clk),
        .rst       (rst),
        .in_data   (in_beat),
        .in_valid  (in_beat_valid),
        .in_ready  (in_beat_ready),
        .out_data  (out_beat),
        .out_valid (out_beat_valid),
        .out_ready (out_beat_ready)
    );

endmodule

/* verilog/echo_collect.sv */
`timescale 1ns/1ps
`include "udp_echo_config.svh"

module echo_collect
    import udp_echo_pkg::*;
#(
    parameter int LANES = `ECHO_LANES
) (
    input  logic              clk,
    input  logic              rst,

    input  udp_hdr_t          lane_hdr [LANES],
    input  logic [LANES-1:0]  lane_hdr_valid,
    output logic [LANES-1:0]  lane_hdr_ready,
    input  payload_beat_t     lane_beat [LANES],
    input  logic [LANES-1:0]  lane_beat_valid,
    output logic [LANES-1:0]  lane_beat_ready,

    output udp_hdr_t          tx_hdr,
    output logic              tx_hdr_valid,
    input  logic              tx_hdr_ready,
    output payload_beat_t     tx_beat,
    output logic              tx_beat_valid,
    input  logic              tx_beat_ready,

    output logic [7:0]        led
);
    localparam int PTR_W = (LANES > 1) ? $clog2(LANES) : 1;

    typedef enum logic {ST_HDR, ST_PAYLOAD} state_t;

    state_t           state;
    logic [PTR_W-1:0] lane_ptr;
    logic             first_beat;
    logic             hdr_fire;
    logic             beat_fire;

    // selected lane drives the transmit side
    assign tx_hdr        = lane_hdr[lane_ptr];
    assign tx_hdr_valid  = (state == ST_HDR) && lane_hdr_valid[lane_ptr];
    assign tx_beat       = lane_beat[lane_ptr];
    assign tx_beat_valid = (state == ST_PAYLOAD) && lane_beat_valid[lane_ptr];

    always_comb begin
        lane_hdr_ready  = '0;
        lane_beat_ready = '0;
        lane_hdr_ready[lane_ptr]  = (state == ST_HDR) && tx_hdr_ready;
        lane_beat_ready[lane_ptr] = (state == ST_PAYLOAD) && tx_beat_ready;
    end

    assign hdr_fire  = tx_hdr_valid && tx_hdr_ready;
    assign beat_fire = tx_beat_valid && tx_beat_ready;

    // same lane order as the dispatcher, so replies keep request order
    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= ST_HDR;
            lane_ptr   <= '0;
            first_beat <= 1'b0;
            led        <= '0;
        end else begin
            case (state)
                ST_HDR: begin
                    if (hdr_fire) begin
                        state      <= ST_PAYLOAD;
                        first_beat <= 1'b1;
                    end
                end
                ST_PAYLOAD: begin
                    if (beat_fire) begin
                        first_beat <= 1'b0;
                        // show first byte of each reply
                        if (first_beat) begin
                            led <= tx_beat.data;
                        end
                        if (tx_beat.last) begin
                            state    <= ST_HDR;
                            lane_ptr <= (lane_ptr == PTR_W'(LANES - 1)) ? '0 : lane_ptr + 1'b1;
                        end
                    end
                end
                default: state <= ST_HDR;
            endcase
        end
    end

endmodule

/* verilog/udp_echo_top.sv */
`timescale 1ns/1ps
`include "udp_echo_config.svh"

module udp_echo_top
    import udp_echo_pkg::*;
#(
    parameter int LANES = `ECHO_LANES
) (
    input  logic          clk,
    input  logic          rst,

    input  udp_hdr_t      rx_hdr,
    input  logic          rx_hdr_valid,
    output logic          rx_hdr_ready,
    input  payload_beat_t rx_beat,
    input  logic          rx_beat_valid,
    output logic          rx_beat_ready,

    output udp_hdr_t      tx_hdr,
    output logic          tx_hdr_valid,
    input  logic          tx_hdr_ready,
    output payload_beat_t tx_beat,
    output logic          tx_beat_valid,
    input  logic          tx_beat_ready,

    output logic [7:0]    led
);
    // dispatcher to lanes with shared data and per-lane handshake
    udp_hdr_t         in_hdr;
    logic [LANES-1:0] in_hdr_valid;
    logic [LANES-1:0] in_hdr_ready;
    payload_beat_t    in_beat;
    logic [LANES-1:0] in_beat_valid;
    logic [LANES-1:0] in_beat_ready;

    // lanes to collector
    udp_hdr_t         out_hdr [LANES];
    logic [LANES-1:0] out_hdr_valid;
    logic [LANES-1:0] out_hdr_ready;
    payload_beat_t    out_beat [LANES];
    logic [LANES-1:0] out_beat_valid;
    logic [LANES-1:0] out_beat_ready;

    echo_dispatch #(.LANES(LANES)) dispatch0 (
        .clk             (clk),
        .rst             (rst),
        .rx_hdr          (rx_hdr),
        .rx_hdr_valid    (rx_hdr_valid),
        .rx_hdr_ready    (rx_hdr_ready),
        .rx_beat         (rx_beat),
        .rx_beat_valid   (rx_beat_valid),
        .rx_beat_ready   (rx_beat_ready),
        .lane_hdr        (in_hdr),
        .lane_hdr_valid  (in_hdr_valid),
        .lane_hdr_ready  (in_hdr_ready),
        .lane_beat       (in_beat),
        .lane_beat_valid (in_beat_valid),
        .lane_beat_ready (in_beat_ready)
    );

    for (genvar i = 0; i < LANES; i++) begin : g_lane
        echo_lane lane (
            .clk            (clk),
            .rst            (rst),
            .in_hdr         (in_hdr),
            .in_hdr_valid   (in_hdr_valid[i]),
            .in_hdr_ready   (in_hdr_ready[i]),
            .in_beat        (in_beat),
            .in_beat_valid  (in_beat_valid[i]),
            .in_beat_ready  (in_beat_ready[i]),
            .out_hdr        (out_hdr[i]),
            .out_hdr_valid  (out_hdr_valid[i]),
            .out_hdr_ready  (out_hdr_ready[i]),
            .out_beat       (out_beat[i]),
            .out_beat_valid (out_beat_valid[i]),
            .out_beat_ready (out_beat_ready[i])
        );
    end

    echo_collect #(.LANES(LANES)) collect0 (
        .clk             (clk),
        .rst             (rst),
        .lane_hdr        (out_hdr),
        .lane_hdr_valid  (out_hdr_valid),
        .lane_hdr_ready  (out_hdr_ready),
        .lane_beat       (out_beat),
        .lane_beat_valid (out_beat_valid),
        .lane_beat_ready (out_beat_ready),
        .tx_hdr          (tx_hdr),
        .tx_hdr_valid    (tx_hdr_valid),
        .tx_hdr_ready    (tx_hdr_ready),
        .tx_beat         (tx_beat),
        .tx_beat_valid   (tx_beat_valid),
        .tx_beat_ready   (tx_beat_ready),
        .led             (led)
    );

endmodule

/* test/udp_echo_properties.sv */
`timescale 1ns/1ps

module udp_echo_properties
    import udp_echo_pkg::*;
(
    input logic          clk,
    input logic          rst,
    input udp_hdr_t      tx_hdr,
    input logic          tx_hdr_valid,
    input logic          tx_hdr_ready,
    input payload_beat_t tx_beat,
    input logic          tx_beat_valid,
    input logic          tx_beat_ready,
    input logic [7:0]    led
);
    int fail_count = 0;

    // stalled reply header stays put
    assert property (@(posedge clk) disable iff (rst)
        tx_hdr_valid && !tx_hdr_ready |=> tx_hdr_valid && $stable(tx_hdr))
    else begin
        fail_count++;
        $error("tx_hdr dropped or changed while tx_hdr_ready was low");
    end

    // same for payload beats
    assert property (@(posedge clk) disable iff (rst)
        tx_beat_valid && !tx_beat_ready |=> tx_beat_valid && $stable(tx_beat))
    else begin
        fail_count++;
        $error("tx_beat dropped or changed while tx_beat_ready was low");
    end

    // nothing pending once reset has been seen
    assert property (@(posedge clk)
        rst |=> !tx_hdr_valid && !tx_beat_valid && led == 8'h00)
    else begin
        fail_count++;
        $error("tx valid or led not cleared after reset");
    end

endmodule

bind udp_echo_top udp_echo_properties props0 (.*);

/* test/udp_echo_checker.sv */
`timescale 1ns/1ps

module udp_echo_checker
    import udp_echo_pkg::*;
(
    input logic          clk,
    input logic          rst,
    input udp_hdr_t      tx_hdr,
    input logic          tx_hdr_valid,
    input logic          tx_hdr_ready,
    input payload_beat_t tx_beat,
    input logic          tx_beat_valid,
    input logic          tx_beat_ready,
    input logic [7:0]    led
);
    udp_hdr_t      exp_hdr_q [$];
    payload_beat_t exp_beat_q [$];
    int            error_count = 0;
    logic          led_pending = 1'b0;
    logic          first_pending = 1'b0;
    logic          after_reset = 1'b0;
    logic [7:0]    led_expect = '0;

    task automatic add_header(input udp_hdr_t h);
        exp_hdr_q.push_back(h);
    endtask

    task automatic add_beat(input payload_beat_t b);
        exp_beat_q.push_back(b);
    endtask

    // work still owed by the DUT or by this checker
    function automatic int outstanding();
        return exp_hdr_q.size() + exp_beat_q.size() + int'(led_pending) + int'(after_reset);
    endfunction

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got %0h, expected %0h", $time, name, got, exp);
            error_count++;
        end
    endtask

    task automatic unexpected(input string what);
        $display("Error at %0t: %s arrived while nothing was expected", $time, what);
        error_count++;
    endtask

    always @(posedge clk) begin
        udp_hdr_t      h;
        payload_beat_t b;
        if (rst) begin
            after_reset   = 1'b1;
            led_pending   = 1'b0;
            first_pending = 1'b0;
        end else begin
            // first cycle out of reset
            if (after_reset) begin
                compare("led", led, 32'h0);
                compare("tx_hdr_valid", tx_hdr_valid, 32'h0);
                compare("tx_beat_valid", tx_beat_valid, 32'h0);
                after_reset = 1'b0;
            end
            // led was loaded during the reply that just ended
            if (led_pending) begin
                compare("led", led, led_expect);
                led_pending = 1'b0;
            end
            if (tx_hdr_valid && tx_hdr_ready) begin
                if (exp_hdr_q.size() == 0) begin
                    unexpected("reply header");
                end else begin
                    h = exp_hdr_q.pop_front();
                    compare("tx_hdr.src_ip", tx_hdr.src_ip, h.src_ip);
                    compare("tx_hdr.dst_ip", tx_hdr.dst_ip, h.dst_ip);
                    compare("tx_hdr.ttl", tx_hdr.ttl, h.ttl);
                    compare("tx_hdr.src_port", tx_hdr.src_port, h.src_port);
                    compare("tx_hdr.dst_port", tx_hdr.dst_port, h.dst_port);
                    compare("tx_hdr.length", tx_hdr.length, h.length);
                end
                first_pending = 1'b1;
            end
            if (tx_beat_valid && tx_beat_ready) begin
                if (exp_beat_q.size() == 0) begin
                    unexpected("payload beat");
                end else begin
                    b = exp_beat_q.pop_front();
                    compare("tx_beat.data", tx_beat.data, b.data);
                    compare("tx_beat.last", tx_beat.last, b.last);
                    compare("tx_beat.user", tx_beat.user, b.user);
                    if (first_pending) begin
                        led_expect = b.data;
                    end
                end
                first_pending = 1'b0;
                if (tx_beat.last) begin
                    led_pending = 1'b1;
                end
            end
        end
    end

endmodule

/* test/udp_echo_tb.sv */
`timescale 1ns/1ps
`include "udp_echo_config.svh"

module udp_echo_tb
    import udp_echo_pkg::*;
();
    logic          clk;
    logic          rst;
    udp_hdr_t      rx_hdr;
    logic          rx_hdr_valid;
    logic          rx_hdr_ready;
    payload_beat_t rx_beat;
    logic          rx_beat_valid;
    logic          rx_beat_ready;
    udp_hdr_t      tx_hdr;
    logic          tx_hdr_valid;
    logic          tx_hdr_ready;
    payload_beat_t tx_beat;
    logic          tx_beat_valid;
    logic          tx_beat_ready;
    logic [7:0]    led;
    logic          random_ready = 1'b0;

    // payload of the frame about to be sent
    logic [7:0]    stage_data [40];
    logic          stage_user [40];
    // traffic kept for replay
    udp_hdr_t      saved_hdr [20];
    int            saved_len [20];
    logic [7:0]    saved_data [20][40];
    logic          saved_user [20][40];
    int            tests_run = 0;
    int            tests_failed = 0;
    int            errors_seen = 0;

    udp_echo_top dut0 (.*);
    udp_echo_checker chk0 (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // reply side back-pressure
    always @(negedge clk) begin
        tx_hdr_ready  = random_ready ? ($urandom % 2 != 0) : 1'b1;
        tx_beat_ready = random_ready ? ($urandom % 2 != 0) : 1'b1;
    end

    function automatic udp_hdr_t reply_header(input udp_hdr_t req);
        udp_hdr_t rep;
        rep.src_ip   = `ECHO_LOCAL_IP;
        rep.dst_ip   = req.src_ip;
        rep.ttl      = `ECHO_REPLY_TTL;
        rep.src_port = req.dst_port;
        rep.dst_port = req.src_port;
        rep.length   = req.length;
        return rep;
    endfunction

    task automatic abort_run(input string why);
        $display("Timeout: %s", why);
        $display("tests run %0d, failed %0d, run stopped early", tests_run, tests_failed);
        $display("Test failures found");
        $finish;
    endtask

    task automatic wait_accept(input logic hdr_side);
        int waited;
        waited = 0;
        do begin
            @(posedge clk);
            waited++;
            if (waited > 2000) begin
                abort_run(hdr_side ? "rx_hdr never accepted" : "rx_beat never accepted");
            end
        end while (!(hdr_side ? rx_hdr_ready : rx_beat_ready));
    endtask

    task automatic wait_drained();
        int waited;
        waited = 0;
        while (chk0.outstanding() != 0) begin
            @(posedge clk);
            waited++;
            if (waited > 20000) begin
                abort_run("expected replies did not all arrive");
            end
        end
    endtask

    task automatic send_frame(input udp_hdr_t h, input int len);
        int i;
        // only frames for the echo port come back
        if (h.dst_port == `ECHO_PORT) begin
            chk0.add_header(reply_header(h));
            for (i = 0; i < len; i++) begin
                chk0.add_beat('{data: stage_data[i], last: (i == len - 1), user: stage_user[i]});
            end
        end
        @(negedge clk);
        rx_hdr       = h;
        rx_hdr_valid = 1'b1;
        wait_accept(1'b1);
        for (i = 0; i < len; i++) begin
            @(negedge clk);
            rx_hdr_valid  = 1'b0;
            rx_beat       = '{data: stage_data[i], last: (i == len - 1), user: stage_user[i]};
            rx_beat_valid = 1'b1;
            wait_accept(1'b0);
        end
        @(negedge clk);
        rx_beat_valid = 1'b0;
    endtask

    task automatic random_frames();
        int f;
        int i;
        for (f = 0; f < 20; f++) begin
            saved_len[f] = 1 + ($urandom % 40);
            saved_hdr[f] = '{src_ip: $urandom, dst_ip: `ECHO_LOCAL_IP, ttl: 8'($urandom),
                             src_port: 16'($urandom), dst_port: `ECHO_PORT,
                             length: 16'(8 + saved_len[f])};
            for (i = 0; i < 40; i++) begin
                saved_data[f][i] = 8'($urandom);
                saved_user[f][i] = 1'($urandom);
            end
        end
    endtask

    task automatic send_saved();
        int f;
        int i;
        for (f = 0; f < 20; f++) begin
            for (i = 0; i < 40; i++) begin
                stage_data[i] = saved_data[f][i];
                stage_user[i] = saved_user[f][i];
            end
            send_frame(saved_hdr[f], saved_len[f]);
        end
    endtask

    task automatic end_test(input string name);
        int errs;
        errs = chk0.error_count + dut0.props0.fail_count - errors_seen;
        errors_seen += errs;
        tests_run++;
        if (errs == 0) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, errs);
        end
    endtask

    initial begin
        int       seed;
        int       i;
        udp_hdr_t h;
        seed = 23;
        void'($urandom(seed));
        rst           = 1'b1;
        rx_hdr        = '0;
        rx_hdr_valid  = 1'b0;
        rx_beat       = '0;
        rx_beat_valid = 1'b0;
        tx_hdr_ready  = 1'b1;
        tx_beat_ready = 1'b1;
        random_ready  = 1'b0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        h = '{src_ip: 32'h0a000001, dst_ip: `ECHO_LOCAL_IP, ttl: 8'd32,
              src_port: 16'd5555, dst_port: `ECHO_PORT, length: 16'd13};
        for (i = 0; i < 5; i++) begin
            stage_data[i] = 8'h41 + 8'(i);
            stage_user[i] = (i == 3);
        end
        send_frame(h, 5);
        wait_drained();
        end_test("single frame");

        // other port first, then a normal echo
        h.dst_port = 16'd4321;
        send_frame(h, 5);
        h.dst_port = `ECHO_PORT;
        h.src_port = 16'd6000;
        stage_data[0] = 8'hc3;
        send_frame(h, 5);
        wait_drained();
        end_test("port filter");

        random_frames();
        send_saved();
        wait_drained();
        end_test("back to back");

        random_ready = 1'b1;
        send_saved();
        wait_drained();
        random_ready = 1'b0;
        end_test("random tx ready");

        stage_data[0] = 8'h5a;
        stage_user[0] = 1'b0;
        send_frame(h, 1);
        wait_drained();
        @(negedge clk);
        rst = 1'b1;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        wait_drained();
        end_test("led");

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors_seen);
        if (tests_failed == 0 && errors_seen == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

/* flist.f */
+incdir+include
verilog/udp_echo_pkg.sv
verilog/stream_fifo.sv
verilog/echo_dispatch.sv
verilog/echo_lane.sv
verilog/echo_collect.sv
verilog/udp_echo_top.sv
test/udp_echo_properties.sv
test/udp_echo_checker.sv
test/udp_echo_tb.sv
